// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - memPkg.sv
  - sramBank.sv
  - sramArray.sv
  - wbRwPort.sv
  - wbReadPort.sv
  - memSubsystemTop.sv
  - target: test
    files:
      - tbMem_props.sv
      - tbMemSubsystem.sv

// ==== flist.f ====
memPkg.sv
sramBank.sv
sramArray.sv
wbRwPort.sv
wbReadPort.sv
memSubsystemTop.sv
tbMem_props.sv
tbMemSubsystem.sv

// ==== memPkg.sv ====
package memPkg;

	// Word geometry
	localparam int BYTE_COUNT = 4;
	localparam int WORD_SIZE = 8 * BYTE_COUNT;

	// Array geometry from fixed 64-word banks
	localparam int BANK_ADDR_SIZE = 6;
	localparam int BANK_COUNT = 8;
	localparam int ADDR_SIZE = BANK_ADDR_SIZE + $clog2(BANK_COUNT);

	// Data word
	typedef logic [WORD_SIZE-1:0] memWord_t;

	// Word address over the whole array
	typedef logic [ADDR_SIZE-1:0] memAddr_t;

	// Word address inside one bank
	typedef logic [BANK_ADDR_SIZE-1:0] bankAddr_t;

	// One enable bit per byte lane
	typedef logic [BYTE_COUNT-1:0] byteMask_t;

	// Read-write slave FSM
	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		DONE
	} rwState_t;

endpackage

// ==== memSubsystemTop.sv ====
`timescale 1ns/1ns

module memSubsystemTop (
	input  logic              clk0,
	input  logic              rst,

	// Read-write Wishbone port
	input  logic              rwCyc,
	input  logic              rwStb,
	input  logic              rwWe,
	input  memPkg::byteMask_t rwSel,
	input  memPkg::memAddr_t  rwAdr,
	input  memPkg::memWord_t  rwDatW,
	output memPkg::memWord_t  rwDatR,
	output logic              rwAck,

	// Read-only Wishbone port
	input  logic              rCyc,
	input  logic              rStb,
	input  memPkg::memAddr_t  rAdr,
	output memPkg::memWord_t  rDatR,
	output logic              rAck
);

	import memPkg::*;

	// Primary array side
	logic priSelect;
	logic priWriteEnable;
	byteMask_t priWriteMask;
	memAddr_t priAddress;
	memWord_t priDataWrite;
	memWord_t priDataRead;

	// Secondary array side
	logic secSelect;
	memAddr_t secAddress;
	memWord_t secDataRead;

	wbRwPort i_rwPort (
		.clk0           (clk0),
		.rst            (rst),
		.rwCyc          (rwCyc),
		.rwStb          (rwStb),
		.rwWe           (rwWe),
		.rwSel          (rwSel),
		.rwAdr          (rwAdr),
		.rwDatW         (rwDatW),
		.rwDatR         (rwDatR),
		.rwAck          (rwAck),
		.priSelect      (priSelect),
		.priWriteEnable (priWriteEnable),
		.priWriteMask   (priWriteMask),
		.priAddress     (priAddress),
		.priDataWrite   (priDataWrite),
		.priDataRead    (priDataRead)
	);

	sramArray i_array (
		.clk0           (clk0),
		.rst            (rst),
		.priSelect      (priSelect),
		.priWriteEnable (priWriteEnable),
		.priWriteMask   (priWriteMask),
		.priAddress     (priAddress),
		.priDataWrite   (priDataWrite),
		.priDataRead    (priDataRead),
		.secSelect      (secSelect),
		.secAddress     (secAddress),
		.secDataRead    (secDataRead)
	);

	wbReadPort i_readPort (
		.clk0        (clk0),
		.rst         (rst),
		.rCyc        (rCyc),
		.rStb        (rStb),
		.rAdr        (rAdr),
		.rDatR       (rDatR),
		.rAck        (rAck),
		.secSelect   (secSelect),
		.secAddress  (secAddress),
		.secDataRead (secDataRead)
	);

endmodule

// ==== sramArray.sv ====
`timescale 1ns/1ns

module sramArray (
	input  logic              clk0,
	input  logic              rst,

	// Primary read-write side
	input  logic              priSelect,
	input  logic              priWriteEnable,
	input  memPkg::byteMask_t priWriteMask,
	input  memPkg::memAddr_t  priAddress,
	input  memPkg::memWord_t  priDataWrite,
	output memPkg::memWord_t  priDataRead,

	// Secondary read-only side
	input  logic              secSelect,
	input  memPkg::memAddr_t  secAddress,
	output memPkg::memWord_t  secDataRead
);

	import memPkg::*;

	// Bank index taken from the upper address bits
	logic [ADDR_SIZE-1:BANK_ADDR_SIZE] priBank;
	logic [ADDR_SIZE-1:BANK_ADDR_SIZE] secBank;
	logic [ADDR_SIZE-1:BANK_ADDR_SIZE] priBankReg;
	logic [ADDR_SIZE-1:BANK_ADDR_SIZE] secBankReg;

	bankAddr_t priOffset;
	bankAddr_t secOffset;

	logic [BANK_COUNT-1:0] bankWrite;
	memWord_t bankReadA [BANK_COUNT];
	memWord_t bankReadB [BANK_COUNT];

	assign priBank = priAddress[ADDR_SIZE-1:BANK_ADDR_SIZE];
	assign secBank = secAddress[ADDR_SIZE-1:BANK_ADDR_SIZE];
	assign priOffset = priAddress[BANK_ADDR_SIZE-1:0];
	assign secOffset = secAddress[BANK_ADDR_SIZE-1:0];

	// One-hot write enable for the addressed bank
	always_comb begin
		bankWrite = '0;
		if (priSelect && priWriteEnable) begin
			bankWrite[priBank] = 1'b1;
		end
	end

	for (genvar b = 0; b < BANK_COUNT; b++) begin : gBank
		sramBank i_bank (
			.clk0         (clk0),
			.writeEnable  (bankWrite[b]),
			.writeMask    (priWriteMask),
			.writeAddress (priOffset),
			.dataWrite    (priDataWrite),
			.readAddressA (priOffset),
			.readAddressB (secOffset),
			.dataReadA    (bankReadA[b]),
			.dataReadB    (bankReadB[b])
		);
	end

	// Index of the access in flight for the mux on the data cycle
	always_ff @(posedge clk0) begin
		if (rst) begin
			priBankReg <= '0;
			secBankReg <= '0;
		end else begin
			if (priSelect) begin
				priBankReg <= priBank;
			end
			if (secSelect) begin
				secBankReg <= secBank;
			end
		end
	end

	assign priDataRead = bankReadA[priBankReg];
	assign secDataRead = bankReadB[secBankReg];

endmodule

// ==== sramBank.sv ====
`timescale 1ns/1ns

module sramBank (
	input  logic              clk0,

	// Masked write port
	input  logic              writeEnable,
	input  memPkg::byteMask_t writeMask,
	input  memPkg::bankAddr_t writeAddress,
	input  memPkg::memWord_t  dataWrite,

	// Registered read ports
	input  memPkg::bankAddr_t readAddressA,
	input  memPkg::bankAddr_t readAddressB,
	output memPkg::memWord_t  dataReadA,
	output memPkg::memWord_t  dataReadB
);

	import memPkg::*;

	// Storage for one bank
	memWord_t mem [2**BANK_ADDR_SIZE];

	// Byte-lane writes
	always_ff @(posedge clk0) begin
		if (writeEnable) begin
			for (int lane = 0; lane < BYTE_COUNT; lane++) begin
				if (writeMask[lane]) begin
					mem[writeAddress][8*lane +: 8] <= dataWrite[8*lane +: 8];
				end
			end
		end
	end

	// Both reads sample the array before this edge's write lands
	always_ff @(posedge clk0) begin
		dataReadA <= mem[readAddressA];
		dataReadB <= mem[readAddressB];
	end

endmodule

// ==== tbMemSubsystem.sv ====
`timescale 1ns/1ns

module tbMemSubsystem;

	import memPkg::*;

	localparam int MEM_WORDS = 2**ADDR_SIZE;
	localparam int FULL_COUNT = 24;
	localparam int MASK_COUNT = 16;
	localparam int CONC_COUNT = 32;
	// Fill, full words, masks, bank decode, parallel traffic
	localparam int TRANSFER_COUNT = MEM_WORDS + 3*FULL_COUNT + 4*MASK_COUNT
		+ 3*BANK_COUNT + 2*CONC_COUNT;
	localparam int CYCLE_LIMIT = 4 * TRANSFER_COUNT * 3 + 100;
	localparam logic [31:0] RANDOM_SEED = 32'h3fbf_94b1;

	logic clk0;
	logic rst;
	logic rwCyc;
	logic rwStb;
	logic rwWe;
	byteMask_t rwSel;
	memAddr_t rwAdr;
	memWord_t rwDatW;
	memWord_t rwDatR;
	logic rwAck;
	logic rCyc;
	logic rStb;
	memAddr_t rAdr;
	memWord_t rDatR;
	logic rAck;

	// Reference copy of the memory
	memWord_t shadow [MEM_WORDS];
	memAddr_t fullAddr [FULL_COUNT];
	int cycleCount = 0;

	memSubsystemTop i_dut (
		.clk0   (clk0),
		.rst    (rst),
		.rwCyc  (rwCyc),
		.rwStb  (rwStb),
		.rwWe   (rwWe),
		.rwSel  (rwSel),
		.rwAdr  (rwAdr),
		.rwDatW (rwDatW),
		.rwDatR (rwDatR),
		.rwAck  (rwAck),
		.rCyc   (rCyc),
		.rStb   (rStb),
		.rAdr   (rAdr),
		.rDatR  (rDatR),
		.rAck   (rAck)
	);

	initial begin
		clk0 = 1'b0;
		forever #2 clk0 = ~clk0;
	end

	always @(posedge clk0) begin
		cycleCount++;
		if (cycleCount > CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$fatal(1, "timeout");
		end
	end

	// Fill value built from the whole address
	function automatic memWord_t fillWord(input memAddr_t addr);
		return {7'h2b, addr, 7'h15, addr};
	endfunction

	// Few addresses in four banks so reads and writes collide
	function automatic memAddr_t hotAddress();
		return memAddr_t'(($urandom_range(0, 3) << BANK_ADDR_SIZE) | 5);
	endfunction

	function automatic void applyWrite(input memAddr_t addr, input byteMask_t sel,
		input memWord_t data);
		for (int lane = 0; lane < BYTE_COUNT; lane++) begin
			if (sel[lane]) begin
				shadow[addr][8*lane +: 8] = data[8*lane +: 8];
			end
		end
	endfunction

	task automatic checkWord(input string name, input memWord_t expected, input memWord_t actual);
		assert (actual === expected) else begin
			$display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "read data mismatch");
		end
	endtask

	task automatic rwWrite(input memAddr_t addr, input byteMask_t sel, input memWord_t data);
		@(posedge clk0);
		#1;
		rwCyc = 1'b1;
		rwStb = 1'b1;
		rwWe = 1'b1;
		rwSel = sel;
		rwAdr = addr;
		rwDatW = data;
		do begin
			@(posedge clk0);
			#1;
		end while (!rwAck);
		// The write landed on the edge that raised ack
		applyWrite(addr, sel, data);
		@(posedge clk0);
		#1;
		rwCyc = 1'b0;
		rwStb = 1'b0;
		rwWe = 1'b0;
	endtask

	task automatic rwRead(input memAddr_t addr);
		@(posedge clk0);
		#1;
		rwCyc = 1'b1;
		rwStb = 1'b1;
		rwWe = 1'b0;
		rwAdr = addr;
		do begin
			@(posedge clk0);
			#1;
		end while (!rwAck);
		checkWord("rwDatR", shadow[addr], rwDatR);
		@(posedge clk0);
		#1;
		rwCyc = 1'b0;
		rwStb = 1'b0;
	endtask

	task automatic rRead(input memAddr_t addr);
		memWord_t expected;
		@(posedge clk0);
		#1;
		rCyc = 1'b1;
		rStb = 1'b1;
		rAdr = addr;
		// Array reads at the next edge, so take the model between the two
		@(posedge clk0);
		#2;
		expected = shadow[addr];
		do begin
			@(posedge clk0);
			#1;
		end while (!rAck);
		checkWord("rDatR", expected, rDatR);
		@(posedge clk0);
		#1;
		rCyc = 1'b0;
		rStb = 1'b0;
	endtask

	initial begin
		memAddr_t addr;
		bankAddr_t offset;
		void'($urandom(RANDOM_SEED));
		rst = 1'b1;
		rwCyc = 1'b0;
		rwStb = 1'b0;
		rwWe = 1'b0;
		rwSel = '0;
		rwAdr = '0;
		rwDatW = '0;
		rCyc = 1'b0;
		rStb = 1'b0;
		rAdr = '0;
		repeat (4) @(posedge clk0);
		#1;
		rst = 1'b0;

		// Defined contents everywhere
		for (int a = 0; a < MEM_WORDS; a++) begin
			rwWrite(memAddr_t'(a), '1, fillWord(memAddr_t'(a)));
		end

		// Full words spread over every bank
		for (int i = 0; i < FULL_COUNT; i++) begin
			fullAddr[i] = memAddr_t'(((i % BANK_COUNT) << BANK_ADDR_SIZE) | $urandom_range(0, 63));
			rwWrite(fullAddr[i], '1, $urandom());
		end
		for (int i = 0; i < FULL_COUNT; i++) begin
			rwRead(fullAddr[i]);
			rRead(fullAddr[i]);
		end

		// Random byte masks over a known word
		for (int i = 0; i < MASK_COUNT; i++) begin
			addr = memAddr_t'($urandom_range(0, MEM_WORDS - 1));
			rwWrite(addr, '1, 32'hc3a5_5a3c);
			rwWrite(addr, byteMask_t'($urandom_range(0, 15)), $urandom());
			rwRead(addr);
			rRead(addr);
		end

		// Same offset in every bank
		offset = bankAddr_t'($urandom_range(0, 63));
		for (int b = 0; b < BANK_COUNT; b++) begin
			rwWrite(memAddr_t'((b << BANK_ADDR_SIZE) | offset), '1,
				32'hba00_0000 | (b << 16) | offset);
		end
		for (int b = 0; b < BANK_COUNT; b++) begin
			rwRead(memAddr_t'((b << BANK_ADDR_SIZE) | offset));
			rRead(memAddr_t'((b << BANK_ADDR_SIZE) | offset));
		end

		// Writes and reads in flight together
		fork
			for (int i = 0; i < CONC_COUNT; i++) begin
				rwWrite(hotAddress(), byteMask_t'($urandom_range(0, 15)), $urandom());
			end
			for (int i = 0; i < CONC_COUNT; i++) begin
				rRead(hotAddress());
			end
		join

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== tbMem_props.sv ====
`timescale 1ns/1ns

module tbMemProps (
	input logic clk0,
	input logic rst,
	input logic rwCyc,
	input logic rwStb,
	input logic rwAck,
	input logic priSelect,
	input logic rCyc,
	input logic rStb,
	input logic rAck,
	input logic secSelect
);

	logic rwNewReq;
	logic rNewReq;

	// Each slave is idle when it neither drives its select nor acks
	assign rwNewReq = rwCyc && rwStb && !priSelect && !rwAck;
	assign rNewReq = rCyc && rStb && !secSelect && !rAck;

	// Ack exactly two edges after the strobe is taken
	rwAckDelay: assert property (@(posedge clk0) disable iff (rst)
		rwNewReq |=> !rwAck ##1 rwAck)
		else $error("rwAck did not follow the strobe at the second edge");

	rAckDelay: assert property (@(posedge clk0) disable iff (rst)
		rNewReq |=> !rAck ##1 rAck)
		else $error("rAck did not follow the strobe at the second edge");

	// No ack outside a bus cycle, and none without a request behind it
	rwAckInCycle: assert property (@(posedge clk0) disable iff (rst)
		rwAck |-> rwCyc && rwStb && $past(rwNewReq, 2))
		else $error("rwAck without a matching strobe");

	rAckInCycle: assert property (@(posedge clk0) disable iff (rst)
		rAck |-> rCyc && rStb && $past(rNewReq, 2))
		else $error("rAck without a matching strobe");

	// Single-cycle acks
	rwAckPulse: assert property (@(posedge clk0) disable iff (rst) rwAck |=> !rwAck)
		else $error("rwAck held longer than one cycle");

	rAckPulse: assert property (@(posedge clk0) disable iff (rst) rAck |=> !rAck)
		else $error("rAck held longer than one cycle");

	// Acks cleared by reset
	acksAfterReset: assert property (@(posedge clk0) rst |=> !rwAck && !rAck)
		else $error("ack high after a reset cycle");

endmodule

bind memSubsystemTop tbMemProps i_props (.*);

// ==== wbReadPort.sv ====
`timescale 1ns/1ns

module wbReadPort (
	input  logic             clk0,
	input  logic             rst,

	// Wishbone classic slave, read only
	input  logic             rCyc,
	input  logic             rStb,
	input  memPkg::memAddr_t rAdr,
	output memPkg::memWord_t rDatR,
	output logic             rAck,

	// Secondary array side
	output logic             secSelect,
	output memPkg::memAddr_t secAddress,
	input  memPkg::memWord_t secDataRead
);

	import memPkg::*;

	logic accept;

	// No new transfer while one is still in flight
	assign accept = rCyc && rStb && !secSelect && !rAck;

	always_ff @(posedge clk0) begin
		if (rst) begin
			secSelect <= 1'b0;
			rAck <= 1'b0;
		end else begin
			secSelect <= accept;
			rAck <= secSelect;
		end
	end

	always_ff @(posedge clk0) begin
		if (accept) begin
			secAddress <= rAdr;
		end
	end

	// Array data arrives together with the ack
	assign rDatR = secDataRead;

endmodule

// ==== wbRwPort.sv ====
`timescale 1ns/1ns

module wbRwPort (
	input  logic              clk0,
	input  logic              rst,

	// Wishbone classic slave
	input  logic              rwCyc,
	input  logic              rwStb,
	input  logic              rwWe,
	input  memPkg::byteMask_t rwSel,
	input  memPkg::memAddr_t  rwAdr,
	input  memPkg::memWord_t  rwDatW,
	output memPkg::memWord_t  rwDatR,
	output logic              rwAck,

	// Primary array side
	output logic              priSelect,
	output logic              priWriteEnable,
	output memPkg::byteMask_t priWriteMask,
	output memPkg::memAddr_t  priAddress,
	output memPkg::memWord_t  priDataWrite,
	input  memPkg::memWord_t  priDataRead
);

	import memPkg::*;

	rwState_t state;
	logic accept;

	// Captured request
	logic reqWe;
	byteMask_t reqSel;
	memAddr_t reqAdr;
	memWord_t reqDat;

	assign accept = (state == IDLE) && rwCyc && rwStb;

	always_ff @(posedge clk0) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:    state <= accept ? ACCESS : IDLE;
				ACCESS:  state <= DONE;
				DONE:    state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk0) begin
		if (accept) begin
			reqWe <= rwWe;
			reqSel <= rwSel;
			reqAdr <= rwAdr;
			reqDat <= rwDatW;
		end
	end

	// Single array access in ACCESS, ack in DONE
	assign priSelect = (state == ACCESS);
	assign priWriteEnable = reqWe;
	assign priWriteMask = reqSel;
	assign priAddress = reqAdr;
	assign priDataWrite = reqDat;

	assign rwAck = (state == DONE);
	assign rwDatR = priDataRead;

endmodule
